//--- logic/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath width
`define CORE_XLEN 32

// Register file geometry
`define CORE_NREGS 32
`define CORE_REG_AW 5

// Multiply pipeline depth, shared by hazard check and pipe
`define CORE_MUL_STAGES 5

`endif

//--- logic/isa_pkg.sv
`default_nettype none

`include "core_cfg.svh"

package isa_pkg;

  typedef logic [31:0] instr_word_t;
  typedef logic [`CORE_REG_AW-1:0] reg_idx_t;
  typedef logic [`CORE_XLEN-1:0] xlen_t;
  typedef logic [6:0] opcode_t;

  // R-type layout, I-type immediate lives in funct7 and rs2
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t rs2;
    reg_idx_t rs1;
    logic [2:0] funct3;
    reg_idx_t rd;
    opcode_t opcode;
  } rv_instr_t;

  localparam opcode_t OPC_OP = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SRL = 3'b101;
  localparam logic [2:0] F3_OR = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_MUL = 3'b000;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_NONE
  } alu_op_t;

endpackage

`default_nettype wire

//--- logic/pipe_pkg.sv
`default_nettype none

`include "core_cfg.svh"

package pipe_pkg;

  // Decode to ALU stage
  typedef struct packed {
    logic valid;
    isa_pkg::alu_op_t op;
    isa_pkg::reg_idx_t rd;
    isa_pkg::xlen_t a;
    isa_pkg::xlen_t b;
  } alu_req_t;

  // Decode to multiply pipe
  typedef struct packed {
    logic valid;
    isa_pkg::reg_idx_t rd;
    isa_pkg::xlen_t a;
    isa_pkg::xlen_t b;
  } mul_req_t;

  // Write request, also pending record and commit record
  typedef struct packed {
    logic valid;
    isa_pkg::reg_idx_t rd;
    isa_pkg::xlen_t data;
  } wb_req_t;

  // Register usage of the instruction held in decode
  typedef struct packed {
    isa_pkg::reg_idx_t rs1;
    isa_pkg::reg_idx_t rs2;
    isa_pkg::reg_idx_t rd;
    logic rs2_used;
    logic rd_used;
    logic is_alu;
  } src_regs_t;

  // One pending record per multiply stage, index 0 is stage 1
  typedef wb_req_t [`CORE_MUL_STAGES-1:0] mul_pend_t;

endpackage

`default_nettype wire

//--- logic/decode_stage.sv
`default_nettype none

`include "core_cfg.svh"

module decode_stage (
  input  logic clk_i,
  input  logic rst_i,
  input  logic issue_valid_i,
  input  isa_pkg::instr_word_t issue_instr_i,
  input  logic stall_i,
  output isa_pkg::reg_idx_t rs1_idx_o,
  output isa_pkg::reg_idx_t rs2_idx_o,
  input  isa_pkg::xlen_t rs1_data_i,
  input  isa_pkg::xlen_t rs2_data_i,
  output pipe_pkg::src_regs_t src_regs_o,
  output logic issue_stall_o,
  output pipe_pkg::alu_req_t alu_req_o,
  output pipe_pkg::mul_req_t mul_req_o
);

  logic dec_valid_q;
  isa_pkg::rv_instr_t instr_q;
  isa_pkg::alu_op_t op;
  logic is_mul;
  logic use_imm;
  logic rd_used;
  logic stall;
  isa_pkg::reg_idx_t rd_eff;
  isa_pkg::xlen_t imm;

  // Stall only matters when something sits in the register
  assign stall         = dec_valid_q & stall_i;
  assign issue_stall_o = stall;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      dec_valid_q <= 1'b0;
    end else if (!stall) begin
      dec_valid_q <= issue_valid_i;
      instr_q     <= issue_instr_i;
    end
  end

  always_comb begin
    op      = isa_pkg::ALU_NONE;
    is_mul  = 1'b0;
    use_imm = 1'b0;
    case (instr_q.opcode)
      isa_pkg::OPC_OP: begin
        if (instr_q.funct7 == isa_pkg::F7_MULDIV) begin
          is_mul = (instr_q.funct3 == isa_pkg::F3_MUL);
        end else if (instr_q.funct7 == isa_pkg::F7_ALT) begin
          if (instr_q.funct3 == isa_pkg::F3_ADD_SUB) op = isa_pkg::ALU_SUB;
        end else if (instr_q.funct7 == isa_pkg::F7_BASE) begin
          case (instr_q.funct3)
            isa_pkg::F3_ADD_SUB: op = isa_pkg::ALU_ADD;
            isa_pkg::F3_SLL:     op = isa_pkg::ALU_SLL;
            isa_pkg::F3_XOR:     op = isa_pkg::ALU_XOR;
            isa_pkg::F3_SRL:     op = isa_pkg::ALU_SRL;
            isa_pkg::F3_OR:      op = isa_pkg::ALU_OR;
            isa_pkg::F3_AND:     op = isa_pkg::ALU_AND;
            default:             op = isa_pkg::ALU_NONE;
          endcase
        end
      end
      isa_pkg::OPC_OP_IMM: begin
        use_imm = 1'b1;
        case (instr_q.funct3)
          isa_pkg::F3_ADD_SUB: op = isa_pkg::ALU_ADD;
          isa_pkg::F3_XOR:     op = isa_pkg::ALU_XOR;
          isa_pkg::F3_OR:      op = isa_pkg::ALU_OR;
          isa_pkg::F3_AND:     op = isa_pkg::ALU_AND;
          // Shift immediates need a clean upper field
          isa_pkg::F3_SLL: begin
            if (instr_q.funct7 == isa_pkg::F7_BASE) op = isa_pkg::ALU_SLL;
          end
          isa_pkg::F3_SRL: begin
            if (instr_q.funct7 == isa_pkg::F7_BASE) op = isa_pkg::ALU_SRL;
          end
          default: op = isa_pkg::ALU_NONE;
        endcase
      end
      default: op = isa_pkg::ALU_NONE;
    endcase
  end

  // Unsupported encodings still flow down the ALU path, writing nothing
  assign rd_used = is_mul | (op != isa_pkg::ALU_NONE);
  assign rd_eff  = rd_used ? instr_q.rd : '0;
  assign imm     = {{(`CORE_XLEN-12){instr_q.funct7[6]}}, instr_q.funct7, instr_q.rs2};

  assign rs1_idx_o = instr_q.rs1;
  assign rs2_idx_o = instr_q.rs2;

  assign src_regs_o.rs1      = instr_q.rs1;
  assign src_regs_o.rs2      = instr_q.rs2;
  assign src_regs_o.rd       = rd_eff;
  assign src_regs_o.rs2_used = rd_used & ~use_imm;
  assign src_regs_o.rd_used  = rd_used;
  assign src_regs_o.is_alu   = dec_valid_q & ~is_mul;

  assign alu_req_o.valid = dec_valid_q & ~is_mul & ~stall_i;
  assign alu_req_o.op    = op;
  assign alu_req_o.rd    = rd_eff;
  assign alu_req_o.a     = rs1_data_i;
  assign alu_req_o.b     = use_imm ? imm : rs2_data_i;

  assign mul_req_o.valid = dec_valid_q & is_mul & ~stall_i;
  assign mul_req_o.rd    = rd_eff;
  assign mul_req_o.a     = rs1_data_i;
  assign mul_req_o.b     = rs2_data_i;

endmodule

`default_nettype wire

//--- logic/hazard_unit.sv
`default_nettype none

`include "core_cfg.svh"

module hazard_unit (
  input  pipe_pkg::src_regs_t src_regs_i,
  input  pipe_pkg::wb_req_t alu_pend_i,
  input  pipe_pkg::mul_pend_t mul_pend_i,
  output logic stall_o
);

  logic dep;
  logic collide;

  // Any use of the decode registers against one pending destination
  function automatic logic conflict(input pipe_pkg::src_regs_t s, input pipe_pkg::wb_req_t p);
    logic live;
    live = p.valid && (p.rd != '0);
    conflict = live && ((p.rd == s.rs1) ||
                        (s.rs2_used && (p.rd == s.rs2)) ||
                        (s.rd_used && (p.rd == s.rd)));
  endfunction

  always_comb begin
    dep = conflict(src_regs_i, alu_pend_i);
    // Last mul stage is written through this cycle
    for (int i = 0; i < `CORE_MUL_STAGES - 1; i++) begin
      dep = dep | conflict(src_regs_i, mul_pend_i[i]);
    end
  end

  // Writeback is next cycle for the mul, ALU would land on the same port
  assign collide = src_regs_i.is_alu & mul_pend_i[`CORE_MUL_STAGES-2].valid;

  assign stall_o = dep | collide;

endmodule

`default_nettype wire

//--- logic/alu_stage.sv
`default_nettype none

module alu_stage (
  input  logic clk_i,
  input  logic rst_i,
  input  pipe_pkg::alu_req_t req_i,
  output pipe_pkg::wb_req_t wb_o
);

  pipe_pkg::alu_req_t req_q;
  isa_pkg::xlen_t result;
  logic [4:0] shamt;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      req_q.valid <= 1'b0;
    end else begin
      req_q <= req_i;
    end
  end

  assign shamt = req_q.b[4:0];

  always_comb begin
    case (req_q.op)
      isa_pkg::ALU_ADD: result = req_q.a + req_q.b;
      isa_pkg::ALU_SUB: result = req_q.a - req_q.b;
      isa_pkg::ALU_AND: result = req_q.a & req_q.b;
      isa_pkg::ALU_OR:  result = req_q.a | req_q.b;
      isa_pkg::ALU_XOR: result = req_q.a ^ req_q.b;
      isa_pkg::ALU_SLL: result = req_q.a << shamt;
      isa_pkg::ALU_SRL: result = req_q.a >> shamt;
      default:          result = '0;
    endcase
  end

  // Same record serves as the pending entry for hazard checks
  assign wb_o.valid = req_q.valid;
  assign wb_o.rd    = req_q.rd;
  assign wb_o.data  = result;

endmodule

`default_nettype wire

//--- logic/mul_pipe.sv
`default_nettype none

`include "core_cfg.svh"

module mul_pipe (
  input  logic clk_i,
  input  logic rst_i,
  input  pipe_pkg::mul_req_t req_i,
  output pipe_pkg::mul_pend_t pend_o,
  output pipe_pkg::wb_req_t wb_o
);

  localparam int unsigned NSTAGES = `CORE_MUL_STAGES;

  logic [NSTAGES-1:0] vld_q;
  isa_pkg::reg_idx_t rd_q [NSTAGES];
  isa_pkg::xlen_t data_q [NSTAGES];
  isa_pkg::xlen_t product;

  // Low half only
  assign product = req_i.a * req_i.b;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[NSTAGES-2:0], req_i.valid};
    end
  end

  always_ff @(posedge clk_i) begin
    rd_q[0]   <= req_i.rd;
    data_q[0] <= product;
    for (int i = 1; i < NSTAGES; i++) begin
      rd_q[i]   <= rd_q[i-1];
      data_q[i] <= data_q[i-1];
    end
  end

  always_comb begin
    for (int i = 0; i < NSTAGES; i++) begin
      pend_o[i].valid = vld_q[i];
      pend_o[i].rd    = rd_q[i];
      pend_o[i].data  = data_q[i];
    end
  end

  assign wb_o = pend_o[NSTAGES-1];

endmodule

`default_nettype wire

//--- logic/rbank.sv
`default_nettype none

`include "core_cfg.svh"

module rbank (
  input  logic clk_i,
  input  logic rst_i,
  input  isa_pkg::reg_idx_t rs1_idx_i,
  input  isa_pkg::reg_idx_t rs2_idx_i,
  output isa_pkg::xlen_t rs1_data_o,
  output isa_pkg::xlen_t rs2_data_o,
  input  pipe_pkg::wb_req_t alu_wb_i,
  input  pipe_pkg::wb_req_t mul_wb_i,
  output pipe_pkg::wb_req_t commit_o
);

  isa_pkg::xlen_t regs_q [`CORE_NREGS];
  pipe_pkg::wb_req_t wr;
  pipe_pkg::wb_req_t commit_q;
  logic wr_en;

  // Hazard unit keeps the two sources apart
  assign wr    = alu_wb_i.valid ? alu_wb_i : mul_wb_i;
  assign wr_en = wr.valid && (wr.rd != '0);

  // Write-through read with x0 pinned to zero
  function automatic isa_pkg::xlen_t read_port(input isa_pkg::reg_idx_t idx,
                                               input isa_pkg::xlen_t stored,
                                               input logic en,
                                               input pipe_pkg::wb_req_t w);
    if (idx == '0) begin
      read_port = '0;
    end else if (en && (w.rd == idx)) begin
      read_port = w.data;
    end else begin
      read_port = stored;
    end
  endfunction

  assign rs1_data_o = read_port(rs1_idx_i, regs_q[rs1_idx_i], wr_en, wr);
  assign rs2_data_o = read_port(rs2_idx_i, regs_q[rs2_idx_i], wr_en, wr);

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      regs_q[wr.rd] <= wr.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      commit_q.valid <= 1'b0;
    end else begin
      commit_q.valid <= wr_en;
      commit_q.rd    <= wr.rd;
      commit_q.data  <= wr.data;
    end
  end

  assign commit_o = commit_q;

endmodule

`default_nettype wire

//--- logic/core_backend.sv
`default_nettype none

module core_backend (
  input  logic clk_i,
  input  logic rst_i,
  input  logic issue_valid_i,
  input  isa_pkg::instr_word_t issue_instr_i,
  output logic issue_stall_o,
  output logic commit_valid_o,
  output isa_pkg::reg_idx_t commit_rd_o,
  output isa_pkg::xlen_t commit_data_o
);

  logic dec_stall;
  isa_pkg::reg_idx_t rs1_idx;
  isa_pkg::reg_idx_t rs2_idx;
  isa_pkg::xlen_t rs1_data;
  isa_pkg::xlen_t rs2_data;
  pipe_pkg::src_regs_t src_regs;
  pipe_pkg::alu_req_t alu_req;
  pipe_pkg::mul_req_t mul_req;
  pipe_pkg::wb_req_t alu_wb;
  pipe_pkg::wb_req_t mul_wb;
  pipe_pkg::mul_pend_t mul_pend;
  pipe_pkg::wb_req_t commit;

  decode_stage decode_stage (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .issue_valid_i (issue_valid_i),
    .issue_instr_i (issue_instr_i),
    .stall_i       (dec_stall),
    .rs1_idx_o     (rs1_idx),
    .rs2_idx_o     (rs2_idx),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .src_regs_o    (src_regs),
    .issue_stall_o (issue_stall_o),
    .alu_req_o     (alu_req),
    .mul_req_o     (mul_req)
  );

  hazard_unit hazard_unit (
    .src_regs_i (src_regs),
    .alu_pend_i (alu_wb),
    .mul_pend_i (mul_pend),
    .stall_o    (dec_stall)
  );

  alu_stage alu_stage (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (alu_req),
    .wb_o  (alu_wb)
  );

  mul_pipe mul_pipe (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .req_i  (mul_req),
    .pend_o (mul_pend),
    .wb_o   (mul_wb)
  );

  rbank rbank (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .alu_wb_i   (alu_wb),
    .mul_wb_i   (mul_wb),
    .commit_o   (commit)
  );

  assign commit_valid_o = commit.valid;
  assign commit_rd_o    = commit.rd;
  assign commit_data_o  = commit.data;

endmodule

`default_nettype wire

//--- tb/core_checker.sv
`default_nettype none

module core_checker (
  input logic clk_i,
  input logic rst_i,
  input pipe_pkg::wb_req_t alu_wb_i,
  input pipe_pkg::wb_req_t mul_wb_i,
  input pipe_pkg::wb_req_t commit_i
);

  // Number of assertion failures
  int fail_count = 0;

  // One write port, both sources never at once
  write_port_unique: assert property (@(posedge clk_i) disable iff (!rst_i)
    !(alu_wb_i.valid && mul_wb_i.valid))
  else begin
    $error("ALU and MUL write requests valid in the same cycle");
    fail_count++;
  end

  // x0 is never committed
  commit_not_x0: assert property (@(posedge clk_i) disable iff (!rst_i)
    commit_i.valid |-> (commit_i.rd != '0))
  else begin
    $error("Commit record carries rd x0");
    fail_count++;
  end

  commit_idle_after_reset: assert property (@(posedge clk_i) !rst_i |=> !commit_i.valid)
  else begin
    $error("Commit valid high in the cycle after reset");
    fail_count++;
  end

endmodule

`default_nettype wire

//--- tb/tb_core_backend.sv
`default_nettype none

`include "core_cfg.svh"

module tb_core_backend;

  localparam int STALL_LIMIT = 50;
  localparam int DRAIN_LIMIT = 200;

  typedef enum logic [3:0] {K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLL, K_SRL, K_MUL, K_ADDI} kind_t;

  // One program step and the value its rd must end up with
  typedef struct packed {
    kind_t kind;
    isa_pkg::reg_idx_t rd;
    isa_pkg::reg_idx_t rs1;
    isa_pkg::reg_idx_t rs2;
    logic [11:0] imm;
    isa_pkg::xlen_t exp;
  } step_t;

  logic clk_i;
  logic rst_i;
  logic issue_valid_i;
  isa_pkg::instr_word_t issue_instr_i;
  logic issue_stall_o;
  logic commit_valid_o;
  isa_pkg::reg_idx_t commit_rd_o;
  isa_pkg::xlen_t commit_data_o;

  step_t steps[$];
  isa_pkg::xlen_t model_regs [`CORE_NREGS];
  isa_pkg::reg_idx_t pend_rd[$];
  isa_pkg::xlen_t pend_data[$];
  logic [31:0] rng_state = 32'h8da5befb;
  logic [1:0] gap;
  logic timed_out = 1'b0;
  int checks = 0;
  int errors = 0;
  int assert_fails = 0;

  core_backend UUT (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .issue_valid_i  (issue_valid_i),
    .issue_instr_i  (issue_instr_i),
    .issue_stall_o  (issue_stall_o),
    .commit_valid_o (commit_valid_o),
    .commit_rd_o    (commit_rd_o),
    .commit_data_o  (commit_data_o)
  );

  bind rbank core_checker rbank_checks (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .alu_wb_i (alu_wb_i),
    .mul_wb_i (mul_wb_i),
    .commit_i (commit_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input isa_pkg::xlen_t got,
                             input isa_pkg::xlen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic add_step(input kind_t kind, input isa_pkg::reg_idx_t rd,
                          input isa_pkg::reg_idx_t rs1, input isa_pkg::reg_idx_t rs2,
                          input logic [11:0] imm, input isa_pkg::xlen_t exp);
    steps.push_back({kind, rd, rs1, rs2, imm, exp});
  endtask

  task automatic build_table();
    add_step(K_ADDI, 5'd1, 5'd0, 5'd0, 12'd12, 32'd12);
    add_step(K_ADDI, 5'd2, 5'd0, 5'd0, 12'd5, 32'd5);
    add_step(K_ADDI, 5'd3, 5'd0, 5'd0, 12'hff9, 32'hffff_fff9);
    add_step(K_ADD, 5'd4, 5'd1, 5'd2, 12'd0, 32'd17);
    add_step(K_SUB, 5'd5, 5'd1, 5'd2, 12'd0, 32'd7);
    add_step(K_AND, 5'd6, 5'd1, 5'd3, 12'd0, 32'd8);
    add_step(K_OR, 5'd7, 5'd2, 5'd3, 12'd0, 32'hffff_fffd);
    add_step(K_XOR, 5'd8, 5'd1, 5'd2, 12'd0, 32'd9);
    add_step(K_SLL, 5'd9, 5'd2, 5'd2, 12'd0, 32'd160);
    add_step(K_SRL, 5'd10, 5'd3, 5'd2, 12'd0, 32'h07ff_ffff);
    add_step(K_MUL, 5'd11, 5'd1, 5'd2, 12'd0, 32'd60);
    add_step(K_MUL, 5'd12, 5'd3, 5'd2, 12'd0, 32'hffff_ffdd);
    add_step(K_MUL, 5'd13, 5'd11, 5'd1, 12'd0, 32'd720);
    // MUL feeding ALU and ALU feeding MUL
    add_step(K_ADD, 5'd14, 5'd13, 5'd2, 12'd0, 32'd725);
    add_step(K_MUL, 5'd15, 5'd14, 5'd2, 12'd0, 32'd3625);
    add_step(K_MUL, 5'd16, 5'd1, 5'd1, 12'd0, 32'd144);
    add_step(K_ADD, 5'd17, 5'd2, 5'd2, 12'd0, 32'd10);
    add_step(K_ADDI, 5'd0, 5'd1, 5'd0, 12'd99, 32'd111);
    add_step(K_ADD, 5'd18, 5'd0, 5'd2, 12'd0, 32'd5);
    add_step(K_ADD, 5'd4, 5'd4, 5'd1, 12'd0, 32'd29);
    add_step(K_MUL, 5'd4, 5'd4, 5'd4, 12'd0, 32'd841);
    add_step(K_XOR, 5'd19, 5'd4, 5'd3, 12'd0, 32'hffff_fcb0);
    add_step(K_MUL, 5'd20, 5'd3, 5'd3, 12'd0, 32'd49);
    add_step(K_ADDI, 5'd21, 5'd20, 5'd0, 12'hfce, 32'hffff_ffff);
  endtask

  function automatic isa_pkg::instr_word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                                  input step_t s);
    return {f7, s.rs2, s.rs1, f3, s.rd, isa_pkg::OPC_OP};
  endfunction

  function automatic isa_pkg::instr_word_t encode(input step_t s);
    case (s.kind)
      K_ADD:   return r_type(isa_pkg::F7_BASE, isa_pkg::F3_ADD_SUB, s);
      K_SUB:   return r_type(isa_pkg::F7_ALT, isa_pkg::F3_ADD_SUB, s);
      K_AND:   return r_type(isa_pkg::F7_BASE, isa_pkg::F3_AND, s);
      K_OR:    return r_type(isa_pkg::F7_BASE, isa_pkg::F3_OR, s);
      K_XOR:   return r_type(isa_pkg::F7_BASE, isa_pkg::F3_XOR, s);
      K_SLL:   return r_type(isa_pkg::F7_BASE, isa_pkg::F3_SLL, s);
      K_SRL:   return r_type(isa_pkg::F7_BASE, isa_pkg::F3_SRL, s);
      K_MUL:   return r_type(isa_pkg::F7_MULDIV, isa_pkg::F3_MUL, s);
      default: return {s.imm, s.rs1, isa_pkg::F3_ADD_SUB, s.rd, isa_pkg::OPC_OP_IMM};
    endcase
  endfunction

  function automatic isa_pkg::xlen_t reg_value(input isa_pkg::reg_idx_t idx);
    return (idx == '0) ? '0 : model_regs[idx];
  endfunction

  // RV32 semantics with MUL keeping the low word
  function automatic isa_pkg::xlen_t model_result(input kind_t k, input isa_pkg::xlen_t a,
                                                  input isa_pkg::xlen_t b);
    logic [63:0] prod;
    prod = {32'b0, a} * {32'b0, b};
    case (k)
      K_ADD, K_ADDI: return a + b;
      K_SUB:         return a - b;
      K_AND:         return a & b;
      K_OR:          return a | b;
      K_XOR:         return a ^ b;
      K_SLL:         return a << b[4:0];
      K_SRL:         return a >> b[4:0];
      K_MUL:         return prod[31:0];
      default:       return '0;
    endcase
  endfunction

  task automatic accept_step(input step_t s);
    isa_pkg::xlen_t a;
    isa_pkg::xlen_t b;
    isa_pkg::xlen_t res;
    a = reg_value(s.rs1);
    b = (s.kind == K_ADDI) ? {{20{s.imm[11]}}, s.imm} : reg_value(s.rs2);
    res = model_result(s.kind, a, b);
    check_value("model_result", res, s.exp);
    if (s.rd != '0) begin
      model_regs[s.rd] = res;
      pend_rd.push_back(s.rd);
      pend_data.push_back(res);
    end
  endtask

  // Drive one step and hold it until decode takes it
  task automatic issue_step(input int n);
    int waited;
    step_t s;
    s = steps[n];
    waited = 0;
    @(posedge clk_i);
    issue_valid_i <= 1'b1;
    issue_instr_i <= encode(s);
    @(negedge clk_i);
    while (issue_stall_o && waited < STALL_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (issue_stall_o) begin
      $display("Timeout: instruction %0d still stalled after %0d cycles", n, waited);
      errors++;
      timed_out = 1'b1;
    end else begin
      accept_step(s);
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (pend_rd.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (pend_rd.size() != 0) begin
      $display("Timeout: %0d instructions never committed", pend_rd.size());
      errors++;
    end
    // Quiet period to catch a duplicated commit
    repeat (10) @(negedge clk_i);
  endtask

  // Oldest outstanding entry for the committed rd
  always @(negedge clk_i) begin : commit_monitor
    int idx;
    idx = -1;
    if (rst_i && commit_valid_o) begin
      for (int i = 0; i < pend_rd.size(); i++) begin
        if (idx < 0 && pend_rd[i] == commit_rd_o) idx = i;
      end
      if (idx < 0) begin
        $display("Unexpected commit to x%0d at time %0t with nothing outstanding",
                 commit_rd_o, $time);
        errors++;
      end else begin
        check_value("commit_data_o", commit_data_o, pend_data[idx]);
        pend_rd.delete(idx);
        pend_data.delete(idx);
      end
    end
  end

  initial begin
    rst_i = 1'b0;
    issue_valid_i = 1'b0;
    issue_instr_i = '0;
    build_table();
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b1;
    for (int n = 0; n < steps.size() && !timed_out; n++) begin
      rng_state = xorshift(rng_state);
      gap = rng_state[1:0];
      // Consecutive MULs go out back to back
      if (n > 0 && steps[n].kind == K_MUL && steps[n-1].kind == K_MUL) begin
        gap = 2'd0;
      end
      repeat (gap) begin
        @(posedge clk_i);
        issue_valid_i <= 1'b0;
      end
      issue_step(n);
    end
    @(posedge clk_i);
    issue_valid_i <= 1'b0;
    if (!timed_out) drain();
    assert_fails = UUT.rbank.rbank_checks.fail_count;
    $display("Checks %0d, errors %0d, assertion failures %0d", checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/decode_stage.sv
logic/hazard_unit.sv
logic/alu_stage.sv
logic/mul_pipe.sv
logic/rbank.sv
logic/core_backend.sv
tb/core_checker.sv
tb/tb_core_backend.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_core_backend
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --assert
RUN_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= FAIL: see errors above
PASS_MSG  ?= PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi; \
	if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
